/* design/axi_sys_bridge.sv */
`timescale 1ns/10ps
//////////////////////////////
// AXI to system bus bridge
// Single-beat AXI slave issuing one system bus strobe per transfer
// and returning the slave answer on the B or R channel
//////////////////////////////

module axi_sys_bridge (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Write address
  input  logic [ps_bus_pkg::SYS_AW-1:0] awaddr_i,
  input  logic                          awvalid_i,
  output logic                          awready_o,
  // Write data
  input  logic [ps_bus_pkg::SYS_DW-1:0] wdata_i,
  input  logic [ps_bus_pkg::SYS_SW-1:0] wstrb_i,
  input  logic                          wvalid_i,
  output logic                          wready_o,
  // Write response
  output logic [1:0]                    bresp_o,
  output logic                          bvalid_o,
  input  logic                          bready_i,
  // Read address
  input  logic [ps_bus_pkg::SYS_AW-1:0] araddr_i,
  input  logic                          arvalid_i,
  output logic                          arready_o,
  // Read data
  output logic [ps_bus_pkg::SYS_DW-1:0] rdata_o,
  output logic [1:0]                    rresp_o,
  output logic                          rvalid_o,
  input  logic                          rready_i,
  // System bus
  output logic [ps_bus_pkg::SYS_AW-1:0] sys_addr_o,
  output logic [ps_bus_pkg::SYS_DW-1:0] sys_wdata_o,
  output logic [ps_bus_pkg::SYS_SW-1:0] sys_sel_o,
  output logic                          sys_wen_o,
  output logic                          sys_ren_o,
  input  logic [ps_bus_pkg::SYS_DW-1:0] sys_rdata_i,
  input  logic                          sys_err_i,
  input  logic                          sys_ack_i
);

  import ps_bus_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_STROBE,
    ST_WAIT,
    ST_RESP
  } state_t;

  state_t state_q;
  logic   is_wr_q;
  logic   wr_take;
  logic   rd_take;
  logic   ack_take;
  logic   resp_done;

  // Handshake happens while the ready pulse is high
  assign wr_take   = (state_q == ST_IDLE) && awready_o;
  assign rd_take   = (state_q == ST_IDLE) && arready_o;
  assign ack_take  = (state_q == ST_WAIT) && sys_ack_i;
  assign resp_done = (bvalid_o && bready_i) || (rvalid_o && rready_i);

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= ST_IDLE;
      is_wr_q   <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      arready_o <= 1'b0;
      sys_wen_o <= 1'b0;
      sys_ren_o <= 1'b0;
      bvalid_o  <= 1'b0;
      rvalid_o  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (wr_take) begin
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            sys_wen_o <= 1'b1;
            is_wr_q   <= 1'b1;
            state_q   <= ST_STROBE;
          end else if (rd_take) begin
            arready_o <= 1'b0;
            sys_ren_o <= 1'b1;
            is_wr_q   <= 1'b0;
            state_q   <= ST_STROBE;
          end else if (awvalid_i && wvalid_i) begin
            // Write wins over a read arriving together
            awready_o <= 1'b1;
            wready_o  <= 1'b1;
          end else if (arvalid_i) begin
            arready_o <= 1'b1;
          end
        end
        ST_STROBE: begin
          // Strobes are single cycle pulses
          sys_wen_o <= 1'b0;
          sys_ren_o <= 1'b0;
          state_q   <= ST_WAIT;
        end
        ST_WAIT: begin
          if (sys_ack_i) begin
            bvalid_o <= is_wr_q;
            rvalid_o <= !is_wr_q;
            state_q  <= ST_RESP;
          end
        end
        ST_RESP: begin
          if (resp_done) begin
            bvalid_o <= 1'b0;
            rvalid_o <= 1'b0;
            state_q  <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Address, data and response
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (wr_take) begin
      sys_addr_o  <= awaddr_i;
      sys_wdata_o <= wdata_i;
      sys_sel_o   <= wstrb_i;
    end else if (rd_take) begin
      sys_addr_o <= araddr_i;
      sys_sel_o  <= '1;
    end
    // Held stable until the master takes the response
    if (ack_take && is_wr_q) begin
      bresp_o <= sys_err_i ? RESP_SLVERR : RESP_OKAY;
    end
    if (ack_take && !is_wr_q) begin
      rresp_o <= sys_err_i ? RESP_SLVERR : RESP_OKAY;
      rdata_o <= sys_rdata_i;
    end
  end

endmodule

/* design/gpio_port.sv */
`timescale 1ns/10ps
//////////////////////////////
// GPIO pad logic
// Input synchronizer, registered output and tristate enable
//////////////////////////////

module gpio_port #(
  parameter int GPIO_W = 8
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic [GPIO_W-1:0] gpio_dir_i,
  input  logic [GPIO_W-1:0] gpio_out_i,
  input  logic [GPIO_W-1:0] gpio_i,
  output logic [GPIO_W-1:0] gpio_o,
  output logic [GPIO_W-1:0] gpio_t_o,
  output logic [GPIO_W-1:0] gpio_in_o
);

  logic [GPIO_W-1:0] sync_q1;
  logic [GPIO_W-1:0] sync_q2;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q1  <= '0;
      sync_q2  <= '0;
      gpio_o   <= '0;
      // All pins start as inputs
      gpio_t_o <= '1;
    end else begin
      sync_q1  <= gpio_i;
      sync_q2  <= sync_q1;
      gpio_o   <= gpio_out_i;
      gpio_t_o <= ~gpio_dir_i;
    end
  end

  assign gpio_in_o = sync_q2;

endmodule

/* design/hk_regs.sv */
`timescale 1ns/10ps
//////////////////////////////
// Housekeeping registers
// ID, LED and GPIO direction, output and input registers
//////////////////////////////

module hk_regs #(
  parameter int GPIO_W = 8,
  parameter int LED_W  = 8
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic [ps_bus_pkg::SYS_AW-1:0] sys_addr_i,
  input  logic [ps_bus_pkg::SYS_DW-1:0] sys_wdata_i,
  input  logic [ps_bus_pkg::SYS_SW-1:0] sys_sel_i,
  input  logic                          sys_wen_i,
  input  logic                          sys_ren_i,
  output logic [ps_bus_pkg::SYS_DW-1:0] sys_rdata_o,
  output logic                          sys_err_o,
  output logic                          sys_ack_o,
  output logic [LED_W-1:0]              led_o,
  output logic [GPIO_W-1:0]             gpio_dir_o,
  output logic [GPIO_W-1:0]             gpio_out_o,
  input  logic [GPIO_W-1:0]             gpio_in_i
);

  import ps_bus_pkg::*;

  logic [SYS_AW-1:0] ofs;
  logic [SYS_DW-1:0] wmask;
  logic [SYS_DW-1:0] led_ext, dir_ext, out_ext, in_ext;
  logic [SYS_DW-1:0] led_new, dir_new, out_new;
  logic [SYS_DW-1:0] rd_data;
  logic              rd_ok;
  logic              wr_ok;
  logic [LED_W-1:0]  led_q;
  logic [GPIO_W-1:0] dir_q;
  logic [GPIO_W-1:0] out_q;

  // Offset inside the region
  assign ofs = {{(SYS_AW-REGION_LSB){1'b0}}, sys_addr_i[REGION_LSB-1:0]};

  always_comb begin
    for (int b = 0; b < SYS_SW; b++) begin
      wmask[8*b +: 8] = {8{sys_sel_i[b]}};
    end
  end

  // Registers widened to bus width
  always_comb begin
    led_ext = '0;
    dir_ext = '0;
    out_ext = '0;
    in_ext  = '0;
    led_ext[LED_W-1:0]  = led_q;
    dir_ext[GPIO_W-1:0] = dir_q;
    out_ext[GPIO_W-1:0] = out_q;
    in_ext[GPIO_W-1:0]  = gpio_in_i;
  end

  // Byte merge under sys_sel
  assign led_new = (led_ext & ~wmask) | (sys_wdata_i & wmask);
  assign dir_new = (dir_ext & ~wmask) | (sys_wdata_i & wmask);
  assign out_new = (out_ext & ~wmask) | (sys_wdata_i & wmask);

  assign wr_ok = (ofs == HK_LED_OFS) || (ofs == HK_DIR_OFS) || (ofs == HK_OUT_OFS);

  always_comb begin
    rd_data = '0;
    rd_ok   = 1'b1;
    case (ofs)
      HK_ID_OFS:  rd_data = HK_ID;
      HK_LED_OFS: rd_data = led_ext;
      HK_DIR_OFS: rd_data = dir_ext;
      HK_OUT_OFS: rd_data = out_ext;
      HK_IN_OFS:  rd_data = in_ext;
      default:    rd_ok   = 1'b0;
    endcase
  end

  //////////////////////////////
  // Register file
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      led_q     <= '0;
      dir_q     <= '0;
      out_q     <= '0;
      sys_ack_o <= 1'b0;
      sys_err_o <= 1'b0;
    end else begin
      sys_ack_o <= sys_wen_i || sys_ren_i;
      sys_err_o <= (sys_wen_i && !wr_ok) || (sys_ren_i && !rd_ok);
      if (sys_wen_i && (ofs == HK_LED_OFS)) begin
        led_q <= led_new[LED_W-1:0];
      end
      if (sys_wen_i && (ofs == HK_DIR_OFS)) begin
        dir_q <= dir_new[GPIO_W-1:0];
      end
      if (sys_wen_i && (ofs == HK_OUT_OFS)) begin
        out_q <= out_new[GPIO_W-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sys_ren_i) begin
      sys_rdata_o <= rd_data;
    end
  end

  assign led_o      = led_q;
  assign gpio_dir_o = dir_q;
  assign gpio_out_o = out_q;

endmodule

/* design/ps_bus_pkg.sv */
//////////////////////////////
// System bus definitions
// Bus widths, region map, housekeeping offsets and AXI response codes
//////////////////////////////

package ps_bus_pkg;

  //////////////////////////////
  // Bus widths
  //////////////////////////////

  localparam int SYS_AW = 32;
  localparam int SYS_DW = 32;
  localparam int SYS_SW = SYS_DW / 8;

  //////////////////////////////
  // Address map
  //////////////////////////////

  // Region field sits above the per-region offset
  localparam int REGION_LSB = 20;
  localparam int REGION_W   = 4;

  localparam logic [REGION_W-1:0] REGION_HK  = 4'h0;
  localparam logic [REGION_W-1:0] REGION_RAM = 4'h1;

  // Housekeeping register offsets
  localparam logic [SYS_AW-1:0] HK_ID_OFS  = 32'h0000_0000;
  localparam logic [SYS_AW-1:0] HK_LED_OFS = 32'h0000_0004;
  localparam logic [SYS_AW-1:0] HK_DIR_OFS = 32'h0000_0008;
  localparam logic [SYS_AW-1:0] HK_OUT_OFS = 32'h0000_000C;
  localparam logic [SYS_AW-1:0] HK_IN_OFS  = 32'h0000_0010;

  // Fixed ID word
  localparam logic [SYS_DW-1:0] HK_ID = 32'h5053_B001;

  //////////////////////////////
  // AXI responses
  //////////////////////////////

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* design/ps_bus_top.sv */
`timescale 1ns/10ps
//////////////////////////////
// Processor bus subsystem
// AXI bridge, region decoder, housekeeping registers, GPIO and RAM
//////////////////////////////

module ps_bus_top #(
  parameter int GPIO_W    = 8,
  parameter int LED_W     = 8,
  parameter int RAM_DEPTH = 64
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // AXI write
  input  logic [ps_bus_pkg::SYS_AW-1:0] awaddr_i,
  input  logic                          awvalid_i,
  output logic                          awready_o,
  input  logic [ps_bus_pkg::SYS_DW-1:0] wdata_i,
  input  logic [ps_bus_pkg::SYS_SW-1:0] wstrb_i,
  input  logic                          wvalid_i,
  output logic                          wready_o,
  output logic [1:0]                    bresp_o,
  output logic                          bvalid_o,
  input  logic                          bready_i,
  // AXI read
  input  logic [ps_bus_pkg::SYS_AW-1:0] araddr_i,
  input  logic                          arvalid_i,
  output logic                          arready_o,
  output logic [ps_bus_pkg::SYS_DW-1:0] rdata_o,
  output logic [1:0]                    rresp_o,
  output logic                          rvalid_o,
  input  logic                          rready_i,
  // Board pins
  output logic [LED_W-1:0]              led_o,
  input  logic [GPIO_W-1:0]             gpio_i,
  output logic [GPIO_W-1:0]             gpio_o,
  output logic [GPIO_W-1:0]             gpio_t_o
);

  import ps_bus_pkg::*;

  // System bus
  logic [SYS_AW-1:0] sys_addr;
  logic [SYS_DW-1:0] sys_wdata, sys_rdata;
  logic [SYS_SW-1:0] sys_sel;
  logic              sys_wen, sys_ren, sys_err, sys_ack;
  // Slave side
  logic              hk_wen, hk_ren, hk_err, hk_ack;
  logic [SYS_DW-1:0] hk_rdata;
  logic              ram_wen, ram_ren, ram_err, ram_ack;
  logic [SYS_DW-1:0] ram_rdata;
  // GPIO
  logic [GPIO_W-1:0] gpio_dir, gpio_out, gpio_in;

  axi_sys_bridge i_bridge (
    .clk_i, .rst_n_i,
    .awaddr_i, .awvalid_i, .awready_o,
    .wdata_i, .wstrb_i, .wvalid_i, .wready_o,
    .bresp_o, .bvalid_o, .bready_i,
    .araddr_i, .arvalid_i, .arready_o,
    .rdata_o, .rresp_o, .rvalid_o, .rready_i,
    .sys_addr_o (sys_addr), .sys_wdata_o (sys_wdata), .sys_sel_o (sys_sel),
    .sys_wen_o (sys_wen), .sys_ren_o (sys_ren),
    .sys_rdata_i (sys_rdata), .sys_err_i (sys_err), .sys_ack_i (sys_ack)
  );

  sys_bus_decoder i_decoder (
    .clk_i, .rst_n_i,
    .sys_addr_i (sys_addr), .sys_wen_i (sys_wen), .sys_ren_i (sys_ren),
    .sys_rdata_o (sys_rdata), .sys_err_o (sys_err), .sys_ack_o (sys_ack),
    .hk_wen_o (hk_wen), .hk_ren_o (hk_ren),
    .hk_rdata_i (hk_rdata), .hk_err_i (hk_err), .hk_ack_i (hk_ack),
    .ram_wen_o (ram_wen), .ram_ren_o (ram_ren),
    .ram_rdata_i (ram_rdata), .ram_err_i (ram_err), .ram_ack_i (ram_ack)
  );

  hk_regs #(.GPIO_W (GPIO_W), .LED_W (LED_W)) i_hk_regs (
    .clk_i, .rst_n_i,
    .sys_addr_i (sys_addr), .sys_wdata_i (sys_wdata), .sys_sel_i (sys_sel),
    .sys_wen_i (hk_wen), .sys_ren_i (hk_ren),
    .sys_rdata_o (hk_rdata), .sys_err_o (hk_err), .sys_ack_o (hk_ack),
    .led_o, .gpio_dir_o (gpio_dir), .gpio_out_o (gpio_out), .gpio_in_i (gpio_in)
  );

  gpio_port #(.GPIO_W (GPIO_W)) i_gpio_port (
    .clk_i, .rst_n_i,
    .gpio_dir_i (gpio_dir), .gpio_out_i (gpio_out), .gpio_i,
    .gpio_o, .gpio_t_o, .gpio_in_o (gpio_in)
  );

  sys_ram #(.RAM_DEPTH (RAM_DEPTH)) i_sys_ram (
    .clk_i, .rst_n_i,
    .sys_addr_i (sys_addr), .sys_wdata_i (sys_wdata), .sys_sel_i (sys_sel),
    .sys_wen_i (ram_wen), .sys_ren_i (ram_ren),
    .sys_rdata_o (ram_rdata), .sys_err_o (ram_err), .sys_ack_o (ram_ack)
  );

endmodule

/* design/sys_bus_decoder.sv */
`timescale 1ns/10ps
//////////////////////////////
// System bus region decoder
// Routes strobes to the selected slave, muxes the answer back
// and error-acks unmapped regions itself
//////////////////////////////

module sys_bus_decoder (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // From the bridge
  input  logic [ps_bus_pkg::SYS_AW-1:0] sys_addr_i,
  input  logic                          sys_wen_i,
  input  logic                          sys_ren_i,
  output logic [ps_bus_pkg::SYS_DW-1:0] sys_rdata_o,
  output logic                          sys_err_o,
  output logic                          sys_ack_o,
  // Housekeeping slave
  output logic                          hk_wen_o,
  output logic                          hk_ren_o,
  input  logic [ps_bus_pkg::SYS_DW-1:0] hk_rdata_i,
  input  logic                          hk_err_i,
  input  logic                          hk_ack_i,
  // RAM slave
  output logic                          ram_wen_o,
  output logic                          ram_ren_o,
  input  logic [ps_bus_pkg::SYS_DW-1:0] ram_rdata_i,
  input  logic                          ram_err_i,
  input  logic                          ram_ack_i
);

  import ps_bus_pkg::*;

  logic [REGION_W-1:0] region;
  logic [REGION_W-1:0] region_q;
  logic                hit_hk;
  logic                hit_ram;
  logic                strobe;
  logic                unm_ack_q;

  assign region  = sys_addr_i[REGION_LSB +: REGION_W];
  assign hit_hk  = (region == REGION_HK);
  assign hit_ram = (region == REGION_RAM);
  assign strobe  = sys_wen_i || sys_ren_i;

  // Strobes forwarded in the same cycle
  assign hk_wen_o  = sys_wen_i && hit_hk;
  assign hk_ren_o  = sys_ren_i && hit_hk;
  assign ram_wen_o = sys_wen_i && hit_ram;
  assign ram_ren_o = sys_ren_i && hit_ram;

  // Region kept until the slave answers
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      region_q  <= REGION_HK;
      unm_ack_q <= 1'b0;
    end else begin
      if (strobe) begin
        region_q <= region;
      end
      unm_ack_q <= strobe && !hit_hk && !hit_ram;
    end
  end

  //////////////////////////////
  // Response mux
  //////////////////////////////

  always_comb begin
    case (region_q)
      REGION_HK: begin
        sys_ack_o   = hk_ack_i;
        sys_err_o   = hk_err_i;
        sys_rdata_o = hk_rdata_i;
      end
      REGION_RAM: begin
        sys_ack_o   = ram_ack_i;
        sys_err_o   = ram_err_i;
        sys_rdata_o = ram_rdata_i;
      end
      default: begin
        // Unmapped region answers an error with zero data
        sys_ack_o   = unm_ack_q;
        sys_err_o   = unm_ack_q;
        sys_rdata_o = '0;
      end
    endcase
  end

endmodule

/* design/sys_ram.sv */
`timescale 1ns/10ps
//////////////////////////////
// Scratch RAM
// Byte-writable word memory on the system bus
//////////////////////////////

module sys_ram #(
  parameter int RAM_DEPTH = 64
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic [ps_bus_pkg::SYS_AW-1:0] sys_addr_i,
  input  logic [ps_bus_pkg::SYS_DW-1:0] sys_wdata_i,
  input  logic [ps_bus_pkg::SYS_SW-1:0] sys_sel_i,
  input  logic                          sys_wen_i,
  input  logic                          sys_ren_i,
  output logic [ps_bus_pkg::SYS_DW-1:0] sys_rdata_o,
  output logic                          sys_err_o,
  output logic                          sys_ack_o
);

  import ps_bus_pkg::*;

  localparam int IDX_W = $clog2(RAM_DEPTH);
  localparam int BO_W  = $clog2(SYS_SW);

  logic [SYS_DW-1:0] mem [RAM_DEPTH];
  logic [IDX_W-1:0]  idx;

  // Word index wraps inside the region
  assign idx = IDX_W'(sys_addr_i[SYS_AW-1:BO_W] % RAM_DEPTH);

  always_ff @(posedge clk_i) begin
    if (sys_wen_i) begin
      for (int b = 0; b < SYS_SW; b++) begin
        if (sys_sel_i[b]) begin
          mem[idx][8*b +: 8] <= sys_wdata_i[8*b +: 8];
        end
      end
    end
    if (sys_ren_i) begin
      sys_rdata_o <= mem[idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sys_ack_o <= 1'b0;
    end else begin
      sys_ack_o <= sys_wen_i || sys_ren_i;
    end
  end

  // Every RAM access succeeds
  assign sys_err_o = 1'b0;

endmodule

/* ps_bus.f */
design/ps_bus_pkg.sv
design/axi_sys_bridge.sv
design/sys_bus_decoder.sv
design/hk_regs.sv
design/gpio_port.sv
design/sys_ram.sv
design/ps_bus_top.sv
tb/ps_bus_props.sv
tb/tb_ps_bus.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ps_bus testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

(verilator --binary --assert -j 0 --top-module tb_ps_bus -f ps_bus.f -o tb_ps_bus \
  && ./obj_dir/tb_ps_bus +verilator+error+limit+1000) > "$LOG" 2>&1
cat "$LOG"

grep -q "^TESTS PASSED$" "$LOG" \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see $LOG"; exit 1; }

/* tb/ps_bus_props.sv */
`timescale 1ns/10ps
//////////////////////////////
// Handshake properties
// AXI response hold, ready pairing and system bus ack timing
//////////////////////////////

module ps_bus_props (
  input logic                          clk_i,
  input logic                          rst_n_i,
  input logic                          awready_i,
  input logic                          wready_i,
  input logic                          bvalid_i,
  input logic                          bready_i,
  input logic [1:0]                    bresp_i,
  input logic                          rvalid_i,
  input logic                          rready_i,
  input logic [1:0]                    rresp_i,
  input logic [ps_bus_pkg::SYS_DW-1:0] rdata_i,
  input logic                          sys_wen_i,
  input logic                          sys_ren_i,
  input logic                          sys_ack_i
);

  // Read back by the testbench at the end of the run
  int fail_cnt = 0;

  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("bvalid or bresp changed before bready");
    end

  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rresp_i) && $stable(rdata_i))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("rvalid, rresp or rdata changed before rready");
    end

  a_ready_pair: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    awready_i == wready_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("awready and wready differ");
    end

  a_strobe_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(sys_wen_i && sys_ren_i))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("sys_wen and sys_ren high together");
    end

  // Ack exactly one cycle after each strobe, and never without one
  a_strobe_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (sys_wen_i || sys_ren_i) |=> sys_ack_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("strobe not acked one cycle later");
    end

  a_ack_origin: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sys_ack_i |-> $past(sys_wen_i || sys_ren_i))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("ack without a strobe in the previous cycle");
    end

endmodule

bind ps_bus_top ps_bus_props i_props (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .awready_i (awready_o),
  .wready_i  (wready_o),
  .bvalid_i  (bvalid_o),
  .bready_i  (bready_i),
  .bresp_i   (bresp_o),
  .rvalid_i  (rvalid_o),
  .rready_i  (rready_i),
  .rresp_i   (rresp_o),
  .rdata_i   (rdata_o),
  .sys_wen_i (sys_wen),
  .sys_ren_i (sys_ren),
  .sys_ack_i (sys_ack)
);

/* tb/tb_ps_bus.sv */
`timescale 1ns/10ps
//////////////////////////////
// Testbench for ps_bus_top
// Random AXI traffic checked against a register and RAM model
//////////////////////////////

module tb_ps_bus;

  import ps_bus_pkg::*;

  localparam int          GPIO_W     = 8;
  localparam int          LED_W      = 8;
  localparam int          RAM_DEPTH  = 64;
  // 200 transfers of up to 12 cycles, reset and margin
  localparam int          MAX_CYCLES = 3000;
  localparam logic [31:0] HK_BASE    = 32'h0000_0000;
  localparam logic [31:0] RAM_BASE   = 32'h0010_0000;
  localparam logic [31:0] GPIO_MASK  = {{(32-GPIO_W){1'b0}}, {GPIO_W{1'b1}}};
  localparam logic [31:0] LED_MASK   = {{(32-LED_W){1'b0}}, {LED_W{1'b1}}};

  logic              clk_i = 1'b0;
  logic              rst_n_i;
  logic [31:0]       awaddr_i;
  logic              awvalid_i;
  logic              awready_o;
  logic [31:0]       wdata_i;
  logic [3:0]        wstrb_i;
  logic              wvalid_i;
  logic              wready_o;
  logic [1:0]        bresp_o;
  logic              bvalid_o;
  logic              bready_i;
  logic [31:0]       araddr_i;
  logic              arvalid_i;
  logic              arready_o;
  logic [31:0]       rdata_o;
  logic [1:0]        rresp_o;
  logic              rvalid_o;
  logic              rready_i;
  logic [LED_W-1:0]  led_o;
  logic [GPIO_W-1:0] gpio_i;
  logic [GPIO_W-1:0] gpio_o;
  logic [GPIO_W-1:0] gpio_t_o;

  // Reference model
  logic [31:0] ram_model [RAM_DEPTH];
  bit          ram_written [RAM_DEPTH];
  int          written_q [$];
  logic [31:0] led_m;
  logic [31:0] dir_m;
  logic [31:0] out_m;

  logic [31:0] lcg_state  = 32'd35;
  int          err_cnt    = 0;
  int          xfer_cnt   = 0;
  int          cycle_cnt  = 0;
  bit          hold_ready = 1'b0;

  ps_bus_top #(
    .GPIO_W    (GPIO_W),
    .LED_W     (LED_W),
    .RAM_DEPTH (RAM_DEPTH)
  ) i_dut (.*);

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing", cycle_cnt);
      $display("TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {16'h0, lcg_state[31:16]} ^ {lcg_state[15:0], 16'h0};
  endfunction

  function automatic int rand_below(int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r % 32'(n));
  endfunction

  function automatic logic [31:0] merge_bytes(logic [31:0] old_w, logic [31:0] new_w,
                                              logic [3:0] strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
    $display("FAILED %s: expected %h, actual %h", name, exp, act);
    err_cnt++;
  endtask

  // One AXI transfer with a random ready delay on the response
  task automatic axi_xfer(input bit is_wr, input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, output logic [1:0] resp,
                          output logic [31:0] rdata);
    int wait_cnt;
    int lat;
    int dly;
    bit got;
    resp  = 2'b11;
    rdata = '0;
    dly   = hold_ready ? 0 : rand_below(5);
    if (is_wr) begin
      awaddr_i  <= addr;
      wdata_i   <= data;
      wstrb_i   <= strb;
      awvalid_i <= 1'b1;
      wvalid_i  <= 1'b1;
    end else begin
      araddr_i  <= addr;
      arvalid_i <= 1'b1;
    end
    wait_cnt = 0;
    got      = 1'b0;
    while (!got && wait_cnt < 16) begin
      @(posedge clk_i);
      wait_cnt++;
      got = is_wr ? (awready_o && wready_o) : arready_o;
    end
    awvalid_i <= 1'b0;
    wvalid_i  <= 1'b0;
    arvalid_i <= 1'b0;
    if (!got) begin
      $display("No address handshake for the transfer to %h", addr);
      err_cnt++;
      return;
    end
    lat = 0;
    got = 1'b0;
    while (!got && lat < 16) begin
      @(posedge clk_i);
      lat++;
      got = is_wr ? bvalid_o : rvalid_o;
    end
    if (!got) begin
      $display("No response for the transfer to %h", addr);
      err_cnt++;
      return;
    end
    if (lat != 3) begin
      report_mismatch("response latency", 32'd3, 32'(lat));
    end
    resp  = is_wr ? bresp_o : rresp_o;
    rdata = is_wr ? 32'h0 : rdata_o;
    // Response must hold until the ready edge
    if (!hold_ready) begin
      for (int i = 0; i <= dly; i++) begin
        if (i == dly) begin
          bready_i <= is_wr;
          rready_i <= !is_wr;
        end
        @(posedge clk_i);
        if (!(is_wr ? bvalid_o : rvalid_o)) begin
          $display("Response valid dropped before ready for %h", addr);
          err_cnt++;
        end
        if ((is_wr ? bresp_o : rresp_o) != resp) begin
          report_mismatch("held response code", 32'(resp), 32'(is_wr ? bresp_o : rresp_o));
        end
        if (!is_wr && rdata_o != rdata) begin
          report_mismatch("held read data", rdata, rdata_o);
        end
      end
      bready_i <= 1'b0;
      rready_i <= 1'b0;
    end
    xfer_cnt++;
  endtask

  task automatic write_chk(string name, logic [31:0] addr, logic [31:0] data,
                           logic [3:0] strb, logic [1:0] exp_resp);
    logic [1:0]  resp;
    logic [31:0] rd;
    axi_xfer(1'b1, addr, data, strb, resp, rd);
    if (resp != exp_resp) begin
      report_mismatch({name, " bresp"}, 32'(exp_resp), 32'(resp));
    end
  endtask

  task automatic read_chk(string name, logic [31:0] addr, logic [31:0] exp_data,
                          logic [1:0] exp_resp);
    logic [1:0]  resp;
    logic [31:0] rd;
    axi_xfer(1'b0, addr, 32'h0, 4'h0, resp, rd);
    if (resp != exp_resp) begin
      report_mismatch({name, " rresp"}, 32'(exp_resp), 32'(resp));
    end
    if (rd != exp_data) begin
      report_mismatch({name, " rdata"}, exp_data, rd);
    end
  endtask

  task automatic hk_write(logic [31:0] ofs, logic [31:0] data, logic [3:0] strb);
    write_chk("hk write", HK_BASE | ofs, data, strb, RESP_OKAY);
    case (ofs)
      HK_LED_OFS: led_m = merge_bytes(led_m, data, strb) & LED_MASK;
      HK_DIR_OFS: dir_m = merge_bytes(dir_m, data, strb) & GPIO_MASK;
      default:    out_m = merge_bytes(out_m, data, strb) & GPIO_MASK;
    endcase
  endtask

  // Pins first, then register readback
  task automatic check_hk_regs(string name);
    if (led_o != led_m[LED_W-1:0]) begin
      report_mismatch({name, " led_o"}, led_m, 32'(led_o));
    end
    if (gpio_t_o != ~dir_m[GPIO_W-1:0]) begin
      report_mismatch({name, " gpio_t_o"}, ~dir_m & GPIO_MASK, 32'(gpio_t_o));
    end
    if (gpio_o != out_m[GPIO_W-1:0]) begin
      report_mismatch({name, " gpio_o"}, out_m, 32'(gpio_o));
    end
    read_chk({name, " led"}, HK_BASE | HK_LED_OFS, led_m, RESP_OKAY);
    read_chk({name, " dir"}, HK_BASE | HK_DIR_OFS, dir_m, RESP_OKAY);
    read_chk({name, " out"}, HK_BASE | HK_OUT_OFS, out_m, RESP_OKAY);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    int          idx;
    int          word;
    rst_n_i   = 1'b0;
    awaddr_i  = '0;
    awvalid_i = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b0;
    araddr_i  = '0;
    arvalid_i = 1'b0;
    rready_i  = 1'b0;
    gpio_i    = '0;
    led_m     = '0;
    dir_m     = '0;
    out_m     = '0;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);

    read_chk("id read", HK_BASE | HK_ID_OFS, HK_ID, RESP_OKAY);

    // RAM traffic where aliased addresses wrap onto the same word
    for (int n = 0; n < 100; n++) begin
      idx  = rand_below(RAM_DEPTH);
      word = idx + RAM_DEPTH * rand_below(4);
      data = next_rand();
      strb = ram_written[idx] ? 4'(next_rand()) : 4'hF;
      write_chk("ram write", RAM_BASE | 32'(word * 4), data, strb, RESP_OKAY);
      ram_model[idx]   = merge_bytes(ram_model[idx], data, strb);
      ram_written[idx] = 1'b1;
      written_q.push_back(idx);
      if (rand_below(2) == 1) begin
        idx  = written_q[rand_below(written_q.size())];
        word = idx + RAM_DEPTH * rand_below(4);
        read_chk("ram read", RAM_BASE | 32'(word * 4), ram_model[idx], RESP_OKAY);
      end
    end

    for (int n = 0; n < 3; n++) begin
      hk_write(HK_LED_OFS, next_rand(), 4'(next_rand()));
      hk_write(HK_DIR_OFS, next_rand(), 4'(next_rand()));
      hk_write(HK_OUT_OFS, next_rand(), 4'(next_rand()));
      check_hk_regs("hk regs");
    end

    // Input held past the synchronizer before the read
    for (int n = 0; n < 2; n++) begin
      data = next_rand() & GPIO_MASK;
      gpio_i <= data[GPIO_W-1:0];
      repeat (3) @(posedge clk_i);
      read_chk("gpio in", HK_BASE | HK_IN_OFS, data, RESP_OKAY);
    end

    //////////////////////////////
    // Error responses
    //////////////////////////////

    for (int n = 0; n < 3; n++) begin
      addr = {8'h00, 4'(2 + rand_below(14)), 18'(next_rand()), 2'b00};
      write_chk("unmapped write", addr, next_rand(), 4'hF, RESP_SLVERR);
      read_chk("unmapped read", addr, 32'h0, RESP_SLVERR);
      addr = HK_BASE | (32'h14 + 32'(4 * rand_below(1000)));
      write_chk("unknown ofs write", addr, next_rand(), 4'hF, RESP_SLVERR);
      read_chk("unknown ofs read", addr, 32'h0, RESP_SLVERR);
    end
    write_chk("id write", HK_BASE | HK_ID_OFS, next_rand(), 4'hF, RESP_SLVERR);
    write_chk("in write", HK_BASE | HK_IN_OFS, next_rand(), 4'hF, RESP_SLVERR);
    read_chk("id after errors", HK_BASE | HK_ID_OFS, HK_ID, RESP_OKAY);
    check_hk_regs("hk after errors");
    idx = written_q[0];
    read_chk("ram after errors", RAM_BASE | 32'(idx * 4), ram_model[idx], RESP_OKAY);

    // Readies held high the whole time
    hold_ready = 1'b1;
    bready_i <= 1'b1;
    rready_i <= 1'b1;
    for (int n = 0; n < 4; n++) begin
      idx  = rand_below(RAM_DEPTH);
      data = next_rand();
      write_chk("held ready write", RAM_BASE | 32'(idx * 4), data, 4'hF, RESP_OKAY);
      ram_model[idx]   = data;
      ram_written[idx] = 1'b1;
      read_chk("held ready read", RAM_BASE | 32'(idx * 4), data, RESP_OKAY);
    end
    read_chk("held ready id", HK_BASE | HK_ID_OFS, HK_ID, RESP_OKAY);
    bready_i <= 1'b0;
    rready_i <= 1'b0;
    hold_ready = 1'b0;

    repeat (2) @(posedge clk_i);
    $display("Transfers %0d, check errors %0d, assertion failures %0d",
             xfer_cnt, err_cnt, i_dut.i_props.fail_cnt);
    if (err_cnt == 0 && i_dut.i_props.fail_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
